// File: bench/tb_regex_ctrl.sv
/* regex control unit testbench */

`timescale 1ns/1ps

module tb_regex_ctrl
    import regex_ctrl_pkg::*;
();

    // run budget sized from the longest string plus random stalls
    localparam int RUNS           = 8;
    localparam int RUN_BUDGET     = 400;
    localparam int SETUP_BUDGET   = 800;
    localparam int TIMEOUT_CYCLES = RUNS * RUN_BUDGET + SETUP_BUDGET;
    localparam int MEM_WORDS      = 1 << MEM_ADDR_W;

    // how the engine model ends a run
    typedef enum logic [1:0] {
        CMD_NONE,
        CMD_ACCEPT,
        CMD_REJECT,
        CMD_FULL
    } eng_cmd_t;

    logic                  clk;
    logic                  rst                = 1'b1;
    logic                  valid              = 1'b0;
    logic                  ready;
    logic [PTR_W-1:0]      start_cc_pointer   = '0;
    logic [PTR_W-1:0]      end_cc_pointer     = '0;
    logic                  memory_valid;
    logic                  memory_ready       = 1'b0;
    logic [MEM_ADDR_W-1:0] memory_addr;
    logic [MEM_W-1:0]      memory_data        = '0;
    logic                  engine_start_valid;
    logic                  engine_start_ready = 1'b1;
    logic [WIN_W-1:0]      window;
    logic [WIN_CHARS-1:0]  window_enable;
    logic [WIN_CHARS-1:0]  window_end;
    logic                  new_char;
    logic                  engine_flush;
    logic                  any_accept         = 1'b0;
    logic                  any_running        = 1'b0;
    logic                  all_full           = 1'b0;
    logic [WIN_CHARS-1:0]  elaborating_chars  = '0;
    logic                  done;
    logic                  accept;
    logic                  error;

    logic [MEM_W-1:0]      mem [0:MEM_WORDS-1];
    integer                seed        = 32'hcb00c0f3;
    int                    cycles      = 0;
    int                    mismatches  = 0;
    int                    failures    = 0;

    // engine model state
    eng_cmd_t              cmd         = CMD_NONE;
    int                    cmd_after   = 0;
    logic                  run_active  = 1'b0;
    logic [SLOT_W-1:0]     head        = '0;
    logic [1:0]            hold        = '0;
    int                    chars_taken = 0;
    logic [PTR_W-1:0]      next_ptr    = '0;

    // expected first window of the current run
    logic [WIN_W-1:0]      exp_first     = '0;
    logic [WIN_CHARS-1:0]  exp_first_end = '0;

    // char loads in flight are checked two cycles after new_char
    logic                  pend1_valid = 1'b0;
    logic [PTR_W-1:0]      pend1_ptr   = '0;
    logic [CHAR_W-1:0]     pend1_char  = '0;
    logic                  pend2_valid = 1'b0;
    logic [PTR_W-1:0]      pend2_ptr   = '0;
    logic [CHAR_W-1:0]     pend2_char  = '0;

    regex_ctrl_top UUT (.*);

    function automatic logic [CHAR_W-1:0] fill_byte(input int p);
        return CHAR_W'(p) ^ CHAR_W'(p >> 6) ^ 8'h5a;
    endfunction

    // text byte at a character pointer with little-endian bytes in the word
    function automatic logic [CHAR_W-1:0] byte_at(input logic [PTR_W-1:0] p);
        return mem[p[WORD_OFS_W +: MEM_ADDR_W]][p[WORD_OFS_W-1:0]*CHAR_W +: CHAR_W];
    endfunction

    function automatic logic [WIN_CHARS-1:0] slot_mask(input logic [SLOT_W-1:0] s);
        return WIN_CHARS'(1) << s;
    endfunction

    task automatic log_mismatch(input string what);
        mismatches = mismatches + 1;
        $display("Mismatch at %0t: %s", $time, what);
    endtask

    task automatic count_failure(input string what);
        failures = failures + 1;
        $display("Error at %0t: %s", $time, what);
    endtask

    initial
    begin
        for (int w = 0; w < MEM_WORDS; w++)
            for (int b = 0; b < CHARS_PER_WORD; b++)
                mem[w][b*CHAR_W +: CHAR_W] = fill_byte(w * CHARS_PER_WORD + b);
    end

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // memory answers one cycle after a taken request
    always @(posedge clk)
    begin
        if (memory_valid && memory_ready)
            memory_data <= mem[memory_addr];
    end

    // stall generator and engine model share one random stream
    always @(posedge clk)
    begin
        memory_ready <= ($random(seed) & 3) != 0;
        pend2_valid  <= pend1_valid;
        pend2_ptr    <= pend1_ptr;
        pend2_char   <= pend1_char;
        pend1_valid  <= 1'b0;
        if (rst)
        begin
            run_active        <= 1'b0;
            elaborating_chars <= '0;
            any_running       <= 1'b0;
            any_accept        <= 1'b0;
            all_full          <= 1'b0;
        end
        else if (engine_start_valid && engine_start_ready)
        begin
            // head sits in slot 0 after the first load
            run_active        <= 1'b1;
            head              <= '0;
            hold              <= 2'($unsigned($random(seed)) % 3);
            chars_taken       <= 0;
            next_ptr          <= start_cc_pointer + PTR_W'(WIN_CHARS);
            elaborating_chars <= slot_mask('0);
            any_running       <= 1'b1;
        end
        else if (done || error)
        begin
            run_active        <= 1'b0;
            elaborating_chars <= '0;
            any_running       <= 1'b0;
            any_accept        <= 1'b0;
            all_full          <= 1'b0;
        end
        else if (run_active)
        begin
            if (new_char)
            begin
                pend1_valid       <= 1'b1;
                pend1_ptr         <= next_ptr;
                pend1_char        <= byte_at(next_ptr);
                next_ptr          <= next_ptr + 1'b1;
                chars_taken       <= chars_taken + 1;
                head              <= head + 1'b1;
                hold              <= 2'($unsigned($random(seed)) % 3);
                elaborating_chars <= slot_mask(head + 1'b1);
            end
            else if (cmd != CMD_NONE && chars_taken >= cmd_after)
            begin
                case (cmd)
                    CMD_ACCEPT: any_accept <= 1'b1;
                    CMD_FULL:   all_full <= 1'b1;
                    default:
                    begin
                        elaborating_chars <= '0;
                        any_running       <= 1'b0;
                    end
                endcase
            end
            else if (hold != 0)
                hold <= hold - 1'b1;
            else
                // only a later slot busy so the head can move on
                elaborating_chars <= slot_mask(head + 1'b1);
        end
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    reset_quiet: assert property (@(posedge clk)
        $fell(rst) |-> !(done || accept || error || ready || engine_start_valid
                         || new_char || memory_valid))
        else log_mismatch("outputs not low in the first cycle after reset");

    flush_in_reset: assert property (@(posedge clk) rst |-> engine_flush)
        else log_mismatch("engine_flush low during reset");

    misaligned_errors: assert property (@(posedge clk) disable iff (rst)
        valid && memory_valid && start_cc_pointer[SLOT_W-1:0] != '0 |=> error)
        else count_failure("misaligned start did not raise error");

    error_sticky: assert property (@(posedge clk) disable iff (rst) error |=> error)
        else count_failure("error dropped before reset");

    error_no_done: assert property (@(posedge clk) disable iff (rst) error |-> !done)
        else count_failure("done raised while in error");

    first_window: assert property (@(posedge clk) disable iff (rst)
        engine_start_valid && engine_start_ready |=> window == exp_first
                                                     && window_enable == 4'b0111)
        else log_mismatch("first window contents or enables wrong");

    first_window_end: assert property (@(posedge clk) disable iff (rst)
        engine_start_valid && engine_start_ready |=> window_end == exp_first_end)
        else log_mismatch("end flags of the first window wrong");

    loaded_char: assert property (@(posedge clk) disable iff (rst)
        pend2_valid |-> window[pend2_ptr[SLOT_W-1:0]*CHAR_W +: CHAR_W] == pend2_char)
        else log_mismatch("character in window differs from memory byte");

    loaded_end_flag: assert property (@(posedge clk) disable iff (rst)
        pend2_valid |-> window_end[pend2_ptr[SLOT_W-1:0]] == (pend2_ptr == end_cc_pointer))
        else log_mismatch("window_end flag of a loaded slot wrong");

    accept_ends_run: assert property (@(posedge clk) disable iff (rst)
        run_active && any_accept && !done && !error
            |=> done && accept && engine_flush ##1 !done)
        else log_mismatch("accept did not give one done cycle with flush");

    reject_ends_run: assert property (@(posedge clk) disable iff (rst)
        run_active && elaborating_chars == '0 && !any_accept && !done && !error
            |=> done && !accept && engine_flush)
        else log_mismatch("idle engines did not give done without accept");

    full_errors: assert property (@(posedge clk) disable iff (rst)
        run_active && all_full && !any_accept && !done && !error |-> ##[1:2] error)
        else count_failure("all_full did not lead to error");

    stall_blocks_ready: assert property (@(posedge clk) disable iff (rst)
        !memory_ready |-> !ready)
        else log_mismatch("ready high while memory stalls");

    addr_held: assert property (@(posedge clk) disable iff (rst)
        memory_valid && !memory_ready |=> !memory_valid || $stable(memory_addr))
        else log_mismatch("memory_addr moved during a stall");

    no_start_unready: assert property (@(posedge clk) disable iff (rst)
        !ready |=> !engine_start_valid)
        else count_failure("start accepted while ready was low");

    task automatic apply_reset();
        rst <= 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
    endtask

    // one start request and a wait until the run settles
    task automatic run_string(input logic [PTR_W-1:0] s, input logic [PTR_W-1:0] e,
                              input eng_cmd_t c, input int n);
        logic [WIN_CHARS-1:0] end_mask;
        end_mask = '0;
        if (s[PTR_W-1:SLOT_W] == e[PTR_W-1:SLOT_W])
            end_mask[e[SLOT_W-1:0]] = 1'b1;
        @(posedge clk);
        // new pointers only on a cycle memory did not stall
        while (!memory_ready)
            @(posedge clk);
        start_cc_pointer <= s;
        end_cc_pointer   <= e;
        cmd              <= c;
        cmd_after        <= n;
        exp_first        <= {byte_at(s + PTR_W'(3)), byte_at(s + PTR_W'(2)),
                             byte_at(s + PTR_W'(1)), byte_at(s)};
        exp_first_end    <= end_mask;
        valid            <= 1'b1;
        do
            @(posedge clk);
        while (!(valid && ready) && !error);
        valid <= 1'b0;
        while (!done && !error)
            @(posedge clk);
        repeat (2) @(posedge clk);
    endtask

    initial
    begin
        apply_reset();
        run_string(16'h0010, 16'h001a, CMD_ACCEPT, 6);
        run_string(16'h0024, 16'h002d, CMD_REJECT, 9);
        run_string(16'h0040, 16'h0042, CMD_REJECT, 2);
        run_string(16'h0104, 16'h0130, CMD_ACCEPT, 20);
        run_string(16'h0408, 16'h0411, CMD_REJECT, 12);
        run_string(16'h0060, 16'h0070, CMD_ACCEPT, 0);
        run_string(16'h0200, 16'h0220, CMD_FULL, 5);
        apply_reset();
        // misaligned start must hold error until reset
        run_string(16'h0303, 16'h0310, CMD_NONE, 0);
        repeat (4) @(posedge clk);
        apply_reset();
        repeat (3) @(posedge clk);
        $display("Checks finished: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: rtl/char_window.sv
/* character window and slot flags */

`timescale 1ns/1ps

module char_window
    import regex_ctrl_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  fill_op_t             fill_op,
    input  logic                 step,
    input  logic [PTR_W-1:0]     ptr,
    input  logic [PTR_W-1:0]     end_cc_pointer,
    input  logic [WIN_W-1:0]     first_slice,
    input  logic [CHAR_W-1:0]    word_char,
    input  logic [CHAR_W-1:0]    buffered_char,
    input  logic                 single_window_end,
    input  logic [WIN_CHARS-1:0] elaborating_chars,
    output logic [WIN_W-1:0]     window,
    output logic [WIN_CHARS-1:0] window_enable,
    output logic [WIN_CHARS-1:0] window_end,
    output logic                 head_busy
);

    // slot holding the oldest character of the string
    logic [WIN_CHARS-1:0] is_first;
    // slots beyond the end of the string
    logic [WIN_CHARS-1:0] past_end;
    logic [WIN_CHARS-1:0] first_end;
    logic [WIN_CHARS-1:0] first_past;
    logic [WIN_CHARS-1:0] rot_past;
    logic [SLOT_W-1:0]    slot;
    logic [SLOT_W-1:0]    end_slot;
    logic                 first_load;

    function automatic logic [WIN_CHARS-1:0] rotl(input logic [WIN_CHARS-1:0] v);
        return {v[WIN_CHARS-2:0], v[WIN_CHARS-1]};
    endfunction

    assign slot       = ptr[SLOT_W-1:0];
    assign end_slot   = end_cc_pointer[SLOT_W-1:0];
    assign first_load = step && (fill_op == LOAD_FIRST);

    // engines still busy on the head character
    assign head_busy = |(is_first & elaborating_chars);

    // end and past-end flags when the whole string fits the first window
    always_comb
    begin
        first_end  = '0;
        first_past = '0;
        if (single_window_end)
        begin
            first_end[end_slot] = 1'b1;
            for (int i = 0; i < WIN_CHARS; i++)
                first_past[i] = (i > int'(end_slot));
        end
    end

    // past-end spreads one slot per advance from the slot after the end
    assign rot_past = past_end | rotl(past_end) | rotl(window_end);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            window_enable <= '0;
            is_first      <= '0;
            window_end    <= '0;
            past_end      <= '0;
        end
        else if (first_load)
        begin
            // the off slot rotates onto the slot being refilled
            window_enable <= {1'b0, {(WIN_CHARS-1){1'b1}}};
            is_first      <= {{(WIN_CHARS-1){1'b0}}, 1'b1};
            window_end    <= first_end;
            past_end      <= first_past;
        end
        else if (step)
        begin
            window_enable <= rotl(window_enable) & ~rot_past;
            is_first      <= rotl(is_first);
            past_end      <= rot_past;
        end
        else if (fill_op == LOAD_WORD || fill_op == LOAD_BUFFER)
        begin
            // new char replaces the stale flag in its slot
            window_end[slot] <= (ptr == end_cc_pointer);
        end
    end

    // character payload
    always_ff @(posedge clk)
    begin
        if (first_load)
            window <= first_slice;
        else if (fill_op == LOAD_WORD)
            window[slot*CHAR_W +: CHAR_W] <= word_char;
        else if (fill_op == LOAD_BUFFER)
            window[slot*CHAR_W +: CHAR_W] <= buffered_char;
    end

    // after the first load the head marker sits on the slot the next fetch refills
    a_first_onehot: assert property (@(posedge clk) disable iff (rst)
        first_load |=> $onehot(is_first) && is_first[slot])
        else $error("first-character flag not one-hot on the refill slot after load");

endmodule

// File: rtl/regex_ctrl_pkg.sv
/* regex controller shared definitions */

package regex_ctrl_pkg;

    // character and memory geometry
    localparam int CHAR_W         = 8;
    localparam int MEM_W          = 64;
    localparam int MEM_ADDR_W     = 11;
    localparam int PTR_W          = 16;
    localparam int CHARS_PER_WORD = MEM_W / CHAR_W;
    localparam int WORD_OFS_W     = $clog2(CHARS_PER_WORD);

    // sliding window seen by the engines
    localparam int WIN_CHARS      = 4;
    localparam int SLOT_W         = $clog2(WIN_CHARS);
    localparam int WIN_W          = WIN_CHARS * CHAR_W;

    // supervisory FSM states
    typedef enum logic [2:0] {
        IDLE,
        FETCH_FIRST,
        FETCH_WORD,
        FETCH_BUFFERED,
        EXECUTE,
        DONE_ACCEPT,
        DONE_REJECT,
        ERROR
    } ctrl_state_t;

    // window fill command
    // LOAD_FIRST is raised while the first word is requested and committed with step
    typedef enum logic [1:0] {
        NONE,
        LOAD_FIRST,
        LOAD_WORD,
        LOAD_BUFFER
    } fill_op_t;

endpackage

// File: rtl/regex_ctrl_top.sv
/* regex coprocessor control unit */

`timescale 1ns/1ps

module regex_ctrl_top
    import regex_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  valid,
    output logic                  ready,
    input  logic [PTR_W-1:0]      start_cc_pointer,
    input  logic [PTR_W-1:0]      end_cc_pointer,
    output logic                  memory_valid,
    input  logic                  memory_ready,
    output logic [MEM_ADDR_W-1:0] memory_addr,
    input  logic [MEM_W-1:0]      memory_data,
    output logic                  engine_start_valid,
    input  logic                  engine_start_ready,
    output logic [WIN_W-1:0]      window,
    output logic [WIN_CHARS-1:0]  window_enable,
    output logic [WIN_CHARS-1:0]  window_end,
    output logic                  new_char,
    output logic                  engine_flush,
    input  logic                  any_accept,
    input  logic                  any_running,
    input  logic                  all_full,
    input  logic [WIN_CHARS-1:0]  elaborating_chars,
    output logic                  done,
    output logic                  accept,
    output logic                  error
);

    // FSM commands
    fill_op_t            fill_op;
    logic                fetch_req;
    logic                step;
    // fetch unit status and data
    logic                fetch_granted;
    logic                at_word_edge;
    logic                start_misaligned;
    logic                single_window_end;
    logic [PTR_W-1:0]    ptr;
    logic [WIN_W-1:0]    first_slice;
    logic [CHAR_W-1:0]   word_char;
    logic [CHAR_W-1:0]   buffered_char;
    // head slot still being worked on
    logic                head_busy;

    run_control u_run_control (
        .clk                (clk),
        .rst                (rst),
        .valid              (valid),
        .ready              (ready),
        .at_word_edge       (at_word_edge),
        .fetch_granted      (fetch_granted),
        .start_misaligned   (start_misaligned),
        .engine_start_ready (engine_start_ready),
        .any_accept         (any_accept),
        .any_running        (any_running),
        .all_full           (all_full),
        .elaborating_chars  (elaborating_chars),
        .head_busy          (head_busy),
        .fill_op            (fill_op),
        .fetch_req          (fetch_req),
        .step               (step),
        .engine_start_valid (engine_start_valid),
        .new_char           (new_char),
        .engine_flush       (engine_flush),
        .done               (done),
        .accept             (accept),
        .error              (error)
    );

    text_fetch u_text_fetch (
        .clk               (clk),
        .rst               (rst),
        .start_cc_pointer  (start_cc_pointer),
        .end_cc_pointer    (end_cc_pointer),
        .fill_op           (fill_op),
        .fetch_req         (fetch_req),
        .step              (step),
        .memory_valid      (memory_valid),
        .memory_ready      (memory_ready),
        .memory_addr       (memory_addr),
        .memory_data       (memory_data),
        .fetch_granted     (fetch_granted),
        .at_word_edge      (at_word_edge),
        .start_misaligned  (start_misaligned),
        .ptr               (ptr),
        .first_slice       (first_slice),
        .word_char         (word_char),
        .buffered_char     (buffered_char),
        .single_window_end (single_window_end)
    );

    char_window u_char_window (
        .clk               (clk),
        .rst               (rst),
        .fill_op           (fill_op),
        .step              (step),
        .ptr               (ptr),
        .end_cc_pointer    (end_cc_pointer),
        .first_slice       (first_slice),
        .word_char         (word_char),
        .buffered_char     (buffered_char),
        .single_window_end (single_window_end),
        .elaborating_chars (elaborating_chars),
        .window            (window),
        .window_enable     (window_enable),
        .window_end        (window_end),
        .head_busy         (head_busy)
    );

endmodule

// File: rtl/run_control.sv
/* coprocessor run control FSM */

`timescale 1ns/1ps

module run_control
    import regex_ctrl_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 valid,
    output logic                 ready,
    input  logic                 at_word_edge,
    input  logic                 fetch_granted,
    input  logic                 start_misaligned,
    input  logic                 engine_start_ready,
    input  logic                 any_accept,
    input  logic                 any_running,
    input  logic                 all_full,
    input  logic [WIN_CHARS-1:0] elaborating_chars,
    input  logic                 head_busy,
    output fill_op_t             fill_op,
    output logic                 fetch_req,
    output logic                 step,
    output logic                 engine_start_valid,
    output logic                 new_char,
    output logic                 engine_flush,
    output logic                 done,
    output logic                 accept,
    output logic                 error
);

    ctrl_state_t state;
    ctrl_state_t state_next;
    // low for the first cycle out of reset, keeps memory and ready quiet
    logic        armed;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= IDLE;
            armed <= 1'b0;
        end
        else
        begin
            state <= state_next;
            armed <= 1'b1;
        end
    end

    always_comb
    begin
        state_next         = state;
        fill_op            = NONE;
        fetch_req          = 1'b0;
        step               = 1'b0;
        ready              = 1'b0;
        engine_start_valid = 1'b0;
        new_char           = 1'b0;
        done               = 1'b0;
        accept             = 1'b0;
        error              = 1'b0;
        // engines are flushed during reset and at the end of each run
        engine_flush       = rst;

        unique case (state)
            IDLE:
            begin
                // keep the start word requested, ready mirrors memory
                fill_op   = LOAD_FIRST;
                fetch_req = armed;
                ready     = fetch_granted;
                if (valid && armed && start_misaligned)
                    state_next = ERROR;
                else if (valid && fetch_granted)
                    state_next = FETCH_FIRST;
            end
            FETCH_FIRST:
            begin
                // word arrives now, load all four slots and kick the engines
                fill_op            = LOAD_FIRST;
                step               = 1'b1;
                engine_start_valid = 1'b1;
                state_next         = engine_start_ready ? EXECUTE : ERROR;
            end
            EXECUTE:
            begin
                if (any_accept)
                    state_next = DONE_ACCEPT;
                else if (all_full)
                    state_next = ERROR;
                else if (elaborating_chars == '0)
                    state_next = DONE_REJECT;
                else if (!head_busy)
                begin
                    // head char finished, move on to the next one
                    if (at_word_edge)
                    begin
                        fetch_req = 1'b1;
                        if (fetch_granted)
                        begin
                            step       = 1'b1;
                            new_char   = 1'b1;
                            state_next = FETCH_WORD;
                        end
                    end
                    else
                    begin
                        step       = 1'b1;
                        new_char   = 1'b1;
                        state_next = FETCH_BUFFERED;
                    end
                end
            end
            FETCH_WORD, FETCH_BUFFERED:
            begin
                fill_op = (state == FETCH_WORD) ? LOAD_WORD : LOAD_BUFFER;
                if (any_accept)
                    state_next = DONE_ACCEPT;
                else if (any_running)
                    state_next = EXECUTE;
                else
                    state_next = DONE_REJECT;
            end
            DONE_ACCEPT:
            begin
                done         = 1'b1;
                accept       = 1'b1;
                engine_flush = 1'b1;
                state_next   = IDLE;
            end
            DONE_REJECT:
            begin
                done         = 1'b1;
                engine_flush = 1'b1;
                state_next   = IDLE;
            end
            ERROR:
            begin
                // sticky until reset
                error = 1'b1;
            end
            default:
            begin
                state_next = IDLE;
            end
        endcase
    end

    // a run reports completion once, then goes back to idle
    a_done_single: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done held for two cycles");

    a_accept_done: assert property (@(posedge clk) disable iff (rst) accept |-> done)
        else $error("accept without done");

endmodule

// File: rtl/text_fetch.sv
/* text fetch unit */

`timescale 1ns/1ps

module text_fetch
    import regex_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [PTR_W-1:0]      start_cc_pointer,
    input  logic [PTR_W-1:0]      end_cc_pointer,
    input  fill_op_t              fill_op,
    input  logic                  fetch_req,
    input  logic                  step,
    output logic                  memory_valid,
    input  logic                  memory_ready,
    output logic [MEM_ADDR_W-1:0] memory_addr,
    input  logic [MEM_W-1:0]      memory_data,
    output logic                  fetch_granted,
    output logic                  at_word_edge,
    output logic                  start_misaligned,
    output logic [PTR_W-1:0]      ptr,
    output logic [WIN_W-1:0]      first_slice,
    output logic [CHAR_W-1:0]     word_char,
    output logic [CHAR_W-1:0]     buffered_char,
    output logic                  single_window_end
);

    // holds the last fetched memory word
    logic [MEM_W-1:0]                 word_buf;
    // which window-sized slice of the word holds the start
    logic [WORD_OFS_W-SLOT_W-1:0]     slice_idx;

    assign memory_valid  = fetch_req;
    assign fetch_granted = memory_valid && memory_ready;

    // first request addresses the start word and later ones follow ptr
    assign memory_addr = (fill_op == LOAD_FIRST) ? start_cc_pointer[WORD_OFS_W +: MEM_ADDR_W]
                                                 : ptr[WORD_OFS_W +: MEM_ADDR_W];

    // window must start on a slot-0 boundary
    assign start_misaligned = (start_cc_pointer[SLOT_W-1:0] != '0);

    // next character is the first of a new word
    assign at_word_edge = (ptr[WORD_OFS_W-1:0] == '0);

    // ptr still holds the start while the first word arrives
    assign slice_idx   = ptr[WORD_OFS_W-1:SLOT_W];
    assign first_slice = memory_data[slice_idx*WIN_W +: WIN_W];

    // string ends inside the first window
    assign single_window_end = (ptr[PTR_W-1:SLOT_W] == end_cc_pointer[PTR_W-1:SLOT_W]);

    // character picks straight from memory or from the buffer
    assign word_char     = memory_data[ptr[WORD_OFS_W-1:0]*CHAR_W +: CHAR_W];
    assign buffered_char = word_buf[ptr[WORD_OFS_W-1:0]*CHAR_W +: CHAR_W];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ptr <= '0;
        end
        else
        begin
            unique case (fill_op)
                LOAD_FIRST:
                begin
                    // commit skips past the four preloaded chars
                    if (step)
                        ptr <= ptr + PTR_W'(WIN_CHARS);
                    else if (fetch_granted)
                        ptr <= start_cc_pointer;
                end
                LOAD_WORD, LOAD_BUFFER:
                begin
                    ptr <= ptr + 1'b1;
                end
                default:
                begin
                    ptr <= ptr;
                end
            endcase
        end
    end

    // word buffer refreshed whenever a word lands
    always_ff @(posedge clk)
    begin
        if ((fill_op == LOAD_FIRST && step) || fill_op == LOAD_WORD)
            word_buf <= memory_data;
    end

    // a pending request keeps its address until memory takes it
    a_addr_stable: assert property (@(posedge clk) disable iff (rst)
        memory_valid && !memory_ready |=> !memory_valid || $stable(memory_addr))
        else $error("memory_addr changed while waiting on memory_ready");

endmodule

// File: sources.f
rtl/regex_ctrl_pkg.sv
rtl/text_fetch.sv
rtl/char_window.sv
rtl/run_control.sv
rtl/regex_ctrl_top.sv
bench/tb_regex_ctrl.sv
